//--- source/mcntrl_test_pkg.sv
// fixed four-channel build; status payload layout must track PAGE_BITS and FRAME_HEIGHT_BITS
`default_nettype none

package mcntrl_test_pkg;

    localparam int NUM_CHN           = 4;     // memory channels under test
    localparam int CHN_BITS          = 2;     // channel index width
    localparam int FRAME_HEIGHT_BITS = 16;    // line count width
    localparam int PAGE_BITS         = 4;     // page counter width, wraps
    localparam int PAYLOAD_BITS      = PAGE_BITS + FRAME_HEIGHT_BITS + 2;

    localparam logic [15:0] CMD_BASE_ADDR = 16'h00f0;  // command block base
    localparam logic [15:0] CMD_ADDR_MASK = 16'h07f0;  // bits taking part in match
    localparam int          CHN_MODE_BASE = 2;         // chn n mode at +2n, status ctrl +2n+1

    localparam logic [7:0] STATUS_REG_BASE    = 8'h3c;  // chn n reports at base + n
    localparam int         STATUS_PKT_BYTES   = 5;      // address byte + 4 data bytes
    localparam int         PKT_DATA_BITS      = 8 * (STATUS_PKT_BYTES - 1);
    localparam logic [1:0] STATUS_MODE_SINGLE = 2'b01;  // one packet per request

    // mode register view of the data byte
    typedef struct packed {
        logic [4:0] pad;          // not decoded
        logic       suspend;      // level
        logic       next_page;    // pulse
        logic       frame_start;  // pulse
    } cmd_mode_t;

    // status control view of the same byte
    typedef struct packed {
        logic [1:0] mode;  // only STATUS_MODE_SINGLE requests a packet
        logic [5:0] seq;   // echoed in packet byte 1
    } cmd_stat_t;

    typedef union packed {
        cmd_mode_t ctl;
        cmd_stat_t stat;
    } cmd_data_u;

    typedef struct packed {
        logic       we;    // one-cycle write strobe
        logic [3:0] addr;  // low address bits after match
        cmd_data_u  data;
    } cmd_wr_t;

    // controls toward one memory channel
    typedef struct packed {
        logic frame_start;
        logic next_page;
        logic suspend;
    } chn_ctrl_t;

    // progress coming back from one memory channel
    typedef struct packed {
        logic                         page_ready;
        logic                         frame_done;
        logic [FRAME_HEIGHT_BITS-1:0] line_unfinished;
    } chn_mem_t;

    typedef struct packed {
        logic [PAGE_BITS-1:0]         page;
        logic [FRAME_HEIGHT_BITS-1:0] line_unfinished;
        logic                         frame_finished;
        logic                         frame_busy;
    } chn_status_t;

    typedef struct packed {
        logic [7:0] ad;  // address byte while rq, then data bytes
        logic       rq;
    } stat_stream_t;

endpackage

`default_nettype wire

//--- source/cmd_deser.sv
// three-byte commands only (addr lo, addr hi, data), no back-pressure; cmd_stb restarts a command
`default_nettype none

module cmd_deser (
    input  logic                     mclk,
    input  logic                     mrst,
    input  logic [7:0]               cmd_ad,
    input  logic                     cmd_stb,
    output mcntrl_test_pkg::cmd_wr_t cmd_wr
);
    import mcntrl_test_pkg::*;

    logic [1:0]  phase;     // 0 idle, 1 high addr byte, 2 data byte
    logic [15:0] addr_sr;   // low byte shifted in first
    logic        addr_hit;  // masked compare against block base
    logic        wr_we;
    logic [3:0]  wr_addr;
    cmd_data_u   wr_data;

    assign addr_hit = ((addr_sr ^ CMD_BASE_ADDR) & CMD_ADDR_MASK) == 16'h0000;

    // byte phase tracking and write strobe
    always_ff @(posedge mclk) begin
        if (mrst) begin
            phase <= 2'd0;
            wr_we <= 1'b0;
        end else begin
            wr_we <= (phase == 2'd2) && addr_hit;  // 3 cycles after cmd_stb
            if (cmd_stb)
                phase <= 2'd1;  // byte 0 in this cycle
            else if (phase == 2'd1)
                phase <= 2'd2;
            else
                phase <= 2'd0;  // also after data byte
        end
    end

    // address assembly, lo ends up in [7:0]
    always_ff @(posedge mclk) begin
        if (cmd_stb || (phase == 2'd1))
            addr_sr <= {cmd_ad, addr_sr[15:8]};
    end

    // latch decoded write with the data byte
    always_ff @(posedge mclk) begin
        if (phase == 2'd2) begin
            wr_addr <= addr_sr[3:0];  // register select within block
            wr_data <= cmd_ad;
        end
    end

    assign cmd_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

//--- source/chn_frame_ctrl.sv
// one channel; mode reg at CHN_MODE_BASE+2*CHN, status ctrl at the next address; page counter wraps
`default_nettype none

module chn_frame_ctrl #(
    parameter int CHN = 0  // channel index from the generate loop
) (
    input  logic                         mclk,
    input  logic                         mrst,
    input  mcntrl_test_pkg::cmd_wr_t     cmd_wr,
    input  mcntrl_test_pkg::chn_mem_t    mem,
    output mcntrl_test_pkg::chn_ctrl_t   ctrl,
    output mcntrl_test_pkg::chn_status_t status,
    output logic                         status_we,
    output mcntrl_test_pkg::cmd_data_u   status_data
);
    import mcntrl_test_pkg::*;

    logic                 mode_sel;        // write to this channel's mode reg
    logic [PAGE_BITS-1:0] page_cnt;
    logic                 frame_busy;
    logic                 frame_finished;

    assign mode_sel  = cmd_wr.we && (cmd_wr.addr == 4'(CHN_MODE_BASE + 2 * CHN));
    assign status_we = cmd_wr.we && (cmd_wr.addr == 4'(CHN_MODE_BASE + 2 * CHN + 1));
    assign status_data = cmd_wr.data;  // mode decoded downstream

    // pulses and suspend level, 4 cycles after cmd_stb
    always_ff @(posedge mclk) begin
        if (mrst) begin
            ctrl <= '0;
        end else begin
            ctrl.frame_start <= mode_sel && cmd_wr.data.ctl.frame_start;
            ctrl.next_page   <= mode_sel && cmd_wr.data.ctl.next_page;
            if (mode_sel)
                ctrl.suspend <= cmd_wr.data.ctl.suspend;  // held until rewritten
        end
    end

    // pages done within the current frame
    always_ff @(posedge mclk) begin
        if (mrst)
            page_cnt <= '0;
        else if (ctrl.frame_start)
            page_cnt <= '0;
        else if (mem.page_ready)
            page_cnt <= page_cnt + 1'b1;
    end

    // busy and finished are complementary once anything happened
    always_ff @(posedge mclk) begin
        if (mrst) begin
            frame_busy     <= 1'b0;
            frame_finished <= 1'b0;
        end else if (ctrl.frame_start && !mem.frame_done) begin
            frame_busy     <= 1'b1;
            frame_finished <= 1'b0;
        end else if (!ctrl.frame_start && mem.frame_done) begin
            frame_busy     <= 1'b0;
            frame_finished <= 1'b1;
        end
    end

    assign status = '{
        page:            page_cnt,
        line_unfinished: mem.line_unfinished,
        frame_finished:  frame_finished,
        frame_busy:      frame_busy
    };

endmodule

`default_nettype wire

//--- source/status_generate.sv
// single-shot status only; payload and seq sampled on start, no stall inside a packet
`default_nettype none

module status_generate #(
    parameter int CHN = 0  // selects the address byte
) (
    input  logic                          mclk,
    input  logic                          mrst,
    input  logic                          status_we,
    input  mcntrl_test_pkg::cmd_data_u    status_data,
    input  mcntrl_test_pkg::chn_status_t  status,
    output mcntrl_test_pkg::stat_stream_t stream,
    input  logic                          start
);
    import mcntrl_test_pkg::*;

    logic                     rq;        // pending packet
    logic                     single_wr; // status write asking for a packet
    logic [5:0]               seq_pend;  // seq from the last request
    logic [PAYLOAD_BITS-1:0]  payload;
    logic [PKT_DATA_BITS-1:0] pkt_sr;    // bytes 1..4, next byte in [7:0]
    logic [7:0]               addr_byte;

    assign single_wr = status_we && (status_data.stat.mode == STATUS_MODE_SINGLE);
    assign payload   = status;
    assign addr_byte = STATUS_REG_BASE + 8'(CHN);

    // request flag; start wins over a new write
    always_ff @(posedge mclk) begin
        if (mrst)
            rq <= 1'b0;
        else if (start)
            rq <= 1'b0;  // byte 0 taken
        else if (status_we)
            rq <= single_wr;  // other modes cancel
    end

    always_ff @(posedge mclk) begin
        if (single_wr)
            seq_pend <= status_data.stat.seq;
    end

    // snapshot on start, then one byte per cycle
    always_ff @(posedge mclk) begin
        if (start)
            pkt_sr <= PKT_DATA_BITS'({payload[PAYLOAD_BITS-1:2], seq_pend, payload[1:0]});
        else
            pkt_sr <= pkt_sr >> 8;  // drains to zero after byte 4
    end

    // address while waiting, data bytes afterwards
    assign stream = '{ad: (rq ? addr_byte : pkt_sr[7:0]), rq: rq};

endmodule

`default_nettype wire

//--- source/status_router.sv
// fixed priority, channel 0 highest; a granted packet owns the output for STATUS_PKT_BYTES cycles
`default_nettype none

module status_router (
    input  logic                          mclk,
    input  logic                          mrst,
    input  mcntrl_test_pkg::stat_stream_t streams_in [mcntrl_test_pkg::NUM_CHN],
    output logic [mcntrl_test_pkg::NUM_CHN-1:0] starts_out,
    output logic [7:0]                    status_ad,
    output logic                          status_rq,
    input  logic                          status_start
);
    import mcntrl_test_pkg::*;

    logic                busy;      // packet body in flight
    logic [CHN_BITS-1:0] sel;       // owner while busy
    logic [2:0]          byte_cnt;  // data bytes left after this one
    logic [CHN_BITS-1:0] pri;       // lowest requesting channel
    logic                any_rq;
    logic [CHN_BITS-1:0] cur;       // channel shown on the output
    logic                grant;     // byte 0 accepted this cycle

    // priority encoder, scan high to low so channel 0 wins
    always_comb begin
        pri    = '0;
        any_rq = 1'b0;
        for (int i = NUM_CHN - 1; i >= 0; i--) begin
            if (streams_in[i].rq) begin
                pri    = CHN_BITS'(i);
                any_rq = 1'b1;
            end
        end
    end

    assign cur       = busy ? sel : pri;
    assign status_rq = !busy && any_rq;   // no extra latency
    assign status_ad = streams_in[cur].ad;
    assign grant     = status_start && status_rq;

    // forward start only to the current winner
    always_comb begin
        starts_out      = '0;
        starts_out[pri] = grant;
    end

    // ownership for bytes 1..4
    always_ff @(posedge mclk) begin
        if (mrst) begin
            busy     <= 1'b0;
            sel      <= '0;
            byte_cnt <= '0;
        end else if (!busy) begin
            if (grant) begin
                busy     <= 1'b1;
                sel      <= pri;
                byte_cnt <= 3'(STATUS_PKT_BYTES - 2);  // counts down to last byte
            end
        end else if (byte_cnt == 3'd0) begin
            busy <= 1'b0;  // last byte out this cycle
        end else begin
            byte_cnt <= byte_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/mcntrl_test_top.sv
// four-channel test controller; status_start must come only while status_rq is high
`default_nettype none

module mcntrl_test_top (
    input  logic                       mclk,
    input  logic                       mrst,
    input  logic [7:0]                 cmd_ad,        // byte-serial command
    input  logic                       cmd_stb,       // marks address low byte
    output logic [7:0]                 status_ad,     // address then 4 data bytes
    output logic                       status_rq,
    input  logic                       status_start,  // takes byte 0
    output mcntrl_test_pkg::chn_ctrl_t chn_ctrl [mcntrl_test_pkg::NUM_CHN],
    input  mcntrl_test_pkg::chn_mem_t  chn_mem  [mcntrl_test_pkg::NUM_CHN]
);
    import mcntrl_test_pkg::*;

    cmd_wr_t            cmd_wr;                 // shared decoded write
    chn_status_t        chn_status [NUM_CHN];   // controller to generator
    logic               stat_we    [NUM_CHN];
    cmd_data_u          stat_data  [NUM_CHN];
    stat_stream_t       streams    [NUM_CHN];   // generators to router
    logic [NUM_CHN-1:0] starts;

    cmd_deser i_cmd_deser (
        .mclk    (mclk),
        .mrst    (mrst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .cmd_wr  (cmd_wr)
    );

    // one controller and one generator per channel
    for (genvar n = 0; n < NUM_CHN; n++) begin : g_chn
        chn_frame_ctrl #(
            .CHN (n)
        ) i_frame_ctrl (
            .mclk        (mclk),
            .mrst        (mrst),
            .cmd_wr      (cmd_wr),
            .mem         (chn_mem[n]),
            .ctrl        (chn_ctrl[n]),
            .status      (chn_status[n]),
            .status_we   (stat_we[n]),
            .status_data (stat_data[n])
        );

        status_generate #(
            .CHN (n)
        ) i_status_gen (
            .mclk        (mclk),
            .mrst        (mrst),
            .status_we   (stat_we[n]),
            .status_data (stat_data[n]),
            .status      (chn_status[n]),
            .stream      (streams[n]),
            .start       (starts[n])
        );
    end

    status_router i_status_router (
        .mclk         (mclk),
        .mrst         (mrst),
        .streams_in   (streams),
        .starts_out   (starts),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

`default_nettype wire

//--- tests/mcntrl_test_checker.sv
// assumes commands at least three cycles apart; a request may fall only on start or a status write
`default_nettype none

module mcntrl_test_checker (
    input logic mclk,
    input logic mrst,
    input logic rq,       // status request toward the receiver
    input logic start,    // byte 0 accepted
    input logic cancel,   // status control write that may withdraw rq
    input logic pulse_a,  // frame_start
    input logic pulse_b   // next_page
);

    int unsigned fail_cnt = 0;  // read by the testbench at the end

    a_start_in_rq: assert property (@(posedge mclk) disable iff (mrst) start |-> rq)
        else begin
            $error("status_start seen while status_rq low");
            fail_cnt++;
        end

    // request held until taken, unless a status write withdrew it
    a_rq_held: assert property (@(posedge mclk) disable iff (mrst)
        rq && !start && !cancel |=> rq)
        else begin
            $error("status request dropped before start without a status write");
            fail_cnt++;
        end

    a_rq_after_start: assert property (@(posedge mclk) disable iff (mrst) start |=> !rq)
        else begin
            $error("status_rq still high on the cycle after status_start");
            fail_cnt++;
        end

    a_frame_start_len: assert property (@(posedge mclk) disable iff (mrst) pulse_a |=> !pulse_a)
        else begin
            $error("frame_start longer than one cycle");
            fail_cnt++;
        end

    a_next_page_len: assert property (@(posedge mclk) disable iff (mrst) pulse_b |=> !pulse_b)
        else begin
            $error("next_page longer than one cycle");
            fail_cnt++;
        end

endmodule

bind status_router mcntrl_test_checker i_handshake_chk (
    .mclk (mclk), .mrst (mrst), .rq (status_rq), .start (status_start), .cancel (1'b1),
    .pulse_a (1'b0), .pulse_b (1'b0)
);

bind status_generate mcntrl_test_checker i_stream_chk (
    .mclk (mclk), .mrst (mrst), .rq (stream.rq), .start (start), .cancel (status_we),
    .pulse_a (1'b0), .pulse_b (1'b0)
);

bind chn_frame_ctrl mcntrl_test_checker i_pulse_chk (
    .mclk (mclk), .mrst (mrst), .rq (1'b0), .start (1'b0), .cancel (1'b0),
    .pulse_a (ctrl.frame_start), .pulse_b (ctrl.next_page)
);

`default_nettype wire

//--- tests/tb_mcntrl_test.sv
// single stimulus thread; no frame_done or page_ready while a packet is read; commands back to back
`default_nettype none

module tb_mcntrl_test;
    import mcntrl_test_pkg::*;

    localparam int RQ_TIMEOUT   = 200;  // cycles for status_rq to change
    localparam int QUIET_CYCLES = 20;   // status_rq must stay low this long after a cancel

    logic       mclk;
    logic       mrst;
    logic [7:0] cmd_ad;
    logic       cmd_stb;
    logic [7:0] status_ad;
    logic       status_rq;
    logic       status_start;
    chn_ctrl_t  chn_ctrl [NUM_CHN];
    chn_mem_t   chn_mem  [NUM_CHN];

    logic [PAGE_BITS-1:0]             m_page [NUM_CHN];  // channel model
    logic [FRAME_HEIGHT_BITS-1:0]     m_line [NUM_CHN];
    logic [NUM_CHN-1:0]               m_busy;
    logic [NUM_CHN-1:0]               m_fin;
    logic [NUM_CHN-1:0]               m_susp;
    logic [5:0]                       seqs [NUM_CHN];
    logic [STATUS_PKT_BYTES-1:0][7:0] exp_pkt;  // byte k in [k]
    logic [STATUS_PKT_BYTES-1:0][7:0] got_pkt;
    event                             pkt_got;
    int                               err_cnt;
    int                               err_mark;
    int                               tests_run;
    int                               tests_failed;

    mcntrl_test_top i_dut (
        .mclk (mclk), .mrst (mrst), .cmd_ad (cmd_ad), .cmd_stb (cmd_stb),
        .status_ad (status_ad), .status_rq (status_rq), .status_start (status_start),
        .chn_ctrl (chn_ctrl), .chn_mem (chn_mem)
    );

    initial mclk = 1'b0;
    always #20 mclk = ~mclk;  // period 40

    // address byte, seq with flags, line lo, line hi, page
    function automatic logic [STATUS_PKT_BYTES-1:0][7:0] expected_packet(input int n,
        input logic [5:0] seq, input logic [3:0] page, input logic [15:0] line,
        input logic fin, input logic busy);
        logic [STATUS_PKT_BYTES-1:0][7:0] pkt;
        pkt[0] = STATUS_REG_BASE + 8'(n);
        pkt[1] = {seq, fin, busy};
        pkt[2] = line[7:0];
        pkt[3] = line[15:8];
        pkt[4] = {4'h0, page};  // zero padded on top
        return pkt;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // compares each collected packet
    always @(pkt_got) begin
        for (int k = 0; k < STATUS_PKT_BYTES; k++)
            check_val($sformatf("status_ad byte %0d", k), got_pkt[k], exp_pkt[k]);
    end

    task automatic send_cmd(input logic [15:0] addr, input logic [7:0] data);
        @(posedge mclk);
        cmd_ad  <= addr[7:0];  // byte 0 with strobe
        cmd_stb <= 1'b1;
        @(posedge mclk);
        cmd_ad  <= addr[15:8];
        cmd_stb <= 1'b0;
        @(posedge mclk);
        cmd_ad  <= data;
    endtask

    // pulse lands in window slot 2, four cycles after cmd_stb
    task automatic watch_ctrl(input int n, input logic fs, input logic np,
                              input logic [NUM_CHN-1:0] susp_old);
        logic exp_sus;
        for (int k = 0; k < 4; k++) begin
            @(negedge mclk);
            check_val("status_rq", status_rq, 32'd0);
            for (int c = 0; c < NUM_CHN; c++) begin
                exp_sus = (k >= 2) ? m_susp[c] : susp_old[c];
                check_val($sformatf("chn_ctrl[%0d].frame_start", c), chn_ctrl[c].frame_start,
                          (k == 2 && c == n) ? fs : 1'b0);
                check_val($sformatf("chn_ctrl[%0d].next_page", c), chn_ctrl[c].next_page,
                          (k == 2 && c == n) ? np : 1'b0);
                check_val($sformatf("chn_ctrl[%0d].suspend", c), chn_ctrl[c].suspend, exp_sus);
            end
        end
    endtask

    task automatic mode_write(input int n, input logic [7:0] data);
        logic [NUM_CHN-1:0] susp_old;
        susp_old = m_susp;
        send_cmd(16'(CMD_BASE_ADDR + CHN_MODE_BASE + 2 * n), data);
        m_susp[n] = data[2];  // rewritten on every mode write
        if (data[0]) begin
            m_page[n] = '0;
            m_busy[n] = 1'b1;
            m_fin[n]  = 1'b0;
        end
        watch_ctrl(n, data[0], data[1], susp_old);
    endtask

    task automatic pulse_pages(input int n, input int cnt);
        repeat (cnt) begin
            @(posedge mclk);
            chn_mem[n].page_ready <= 1'b1;
            @(posedge mclk);
            chn_mem[n].page_ready <= 1'b0;
        end
        m_page[n] = m_page[n] + 4'(cnt);  // wraps like the counter
    endtask

    task automatic end_frame(input int n);
        @(posedge mclk);
        chn_mem[n].frame_done <= 1'b1;
        @(posedge mclk);
        chn_mem[n].frame_done <= 1'b0;
        m_busy[n] = 1'b0;
        m_fin[n]  = 1'b1;
    endtask

    task automatic set_line(input int n, input logic [15:0] line);
        @(posedge mclk);
        chn_mem[n].line_unfinished <= line;
        m_line[n] = line;
    endtask

    task automatic request_status(input int n, input logic [1:0] mode, input logic [5:0] seq);
        send_cmd(16'(CMD_BASE_ADDR + CHN_MODE_BASE + 2 * n + 1), {mode, seq});
    endtask

    task automatic wait_rq_level(input logic level, output bit ok);
        int t;
        t = 0;
        @(negedge mclk);
        while (status_rq !== level && t < RQ_TIMEOUT) begin
            @(negedge mclk);
            t++;
        end
        ok = (status_rq === level);
        if (!ok) begin
            $display("Timeout at %0t: status_rq did not go to %0b within %0d cycles",
                     $time, level, RQ_TIMEOUT);
            err_cnt++;
        end
    endtask

    task automatic collect_packet(input logic [STATUS_PKT_BYTES-1:0][7:0] exp);
        bit ok;
        wait_rq_level(1'b1, ok);
        if (ok) begin
            @(posedge mclk);
            status_start <= 1'b1;
            @(negedge mclk);
            got_pkt[0] = status_ad;  // address byte in the start cycle
            @(posedge mclk);
            status_start <= 1'b0;
            for (int k = 1; k < STATUS_PKT_BYTES; k++) begin
                @(negedge mclk);
                got_pkt[k] = status_ad;
            end
            exp_pkt = exp;  // held until the next packet is read
            -> pkt_got;
        end
    endtask

    task automatic end_test(input string name);
        @(posedge mclk);  // compare process done by now
        tests_run++;
        if (err_cnt != err_mark) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, err_cnt - err_mark);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
        err_mark = err_cnt;
    endtask

    function automatic int checker_failures();
        return i_dut.i_status_router.i_handshake_chk.fail_cnt
             + i_dut.g_chn[0].i_frame_ctrl.i_pulse_chk.fail_cnt
             + i_dut.g_chn[1].i_frame_ctrl.i_pulse_chk.fail_cnt
             + i_dut.g_chn[2].i_frame_ctrl.i_pulse_chk.fail_cnt
             + i_dut.g_chn[3].i_frame_ctrl.i_pulse_chk.fail_cnt
             + i_dut.g_chn[0].i_status_gen.i_stream_chk.fail_cnt
             + i_dut.g_chn[1].i_status_gen.i_stream_chk.fail_cnt
             + i_dut.g_chn[2].i_status_gen.i_stream_chk.fail_cnt
             + i_dut.g_chn[3].i_status_gen.i_stream_chk.fail_cnt;
    endfunction

    initial begin
        bit ok;
        int asrt;
        void'($urandom(32'hfb16ffea));
        mrst         <= 1'b1;
        cmd_ad       <= '0;
        cmd_stb      <= 1'b0;
        status_start <= 1'b0;
        for (int c = 0; c < NUM_CHN; c++) begin
            chn_mem[c] <= '0;
            m_page[c]  = '0;
            m_line[c]  = '0;
        end
        m_busy = '0;
        m_fin  = '0;
        m_susp = '0;
        err_cnt = 0;
        err_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (2) @(posedge mclk);
        mrst <= 1'b0;

        @(negedge mclk);
        check_val("status_rq", status_rq, 32'd0);
        for (int c = 0; c < NUM_CHN; c++)
            check_val($sformatf("chn_ctrl[%0d]", c), chn_ctrl[c], 32'd0);
        end_test("reset state");

        for (int n = 0; n < NUM_CHN; n++) begin
            mode_write(n, 8'h01);  // frame_start
            mode_write(n, 8'h06);  // next_page, suspend on
        end
        for (int n = 0; n < NUM_CHN; n++)
            mode_write(n, (n % 2 == 0) ? 8'h05 : 8'h01);  // odd channels release suspend
        end_test("mode pulses and suspend");

        send_cmd(16'h04f2, 8'h07);  // bit 10 off base
        watch_ctrl(NUM_CHN, 1'b0, 1'b0, m_susp);
        send_cmd(16'h00e4, 8'h03);  // bit 4 off base
        watch_ctrl(NUM_CHN, 1'b0, 1'b0, m_susp);
        send_cmd(16'h01f3, 8'h41);  // chn 0 status request, bit 8 off
        watch_ctrl(NUM_CHN, 1'b0, 1'b0, m_susp);
        end_test("address mismatch");

        for (int n = 0; n < NUM_CHN; n++) begin
            set_line(n, 16'($urandom));
            pulse_pages(n, 1 + $urandom % 20);
            if (n >= 2)
                end_frame(n);  // finished on upper channels, busy on lower
            seqs[n] = 6'($urandom);
            request_status(n, STATUS_MODE_SINGLE, seqs[n]);
            collect_packet(expected_packet(n, seqs[n], m_page[n], m_line[n],
                                           m_fin[n], m_busy[n]));
        end
        end_test("single status packet");

        for (int n = 0; n < NUM_CHN; n++) begin
            set_line(n, 16'($urandom));
            seqs[n] = 6'($urandom);
            request_status(n, STATUS_MODE_SINGLE, seqs[n]);
        end
        for (int n = 0; n < NUM_CHN; n++)  // lowest channel first
            collect_packet(expected_packet(n, seqs[n], m_page[n], m_line[n],
                                           m_fin[n], m_busy[n]));
        end_test("four requests in priority order");

        request_status(1, STATUS_MODE_SINGLE, 6'h2a);
        wait_rq_level(1'b1, ok);
        request_status(1, 2'b00, 6'h15);  // cancel before any start
        wait_rq_level(1'b0, ok);
        repeat (QUIET_CYCLES) begin
            @(negedge mclk);
            check_val("status_rq", status_rq, 32'd0);
        end
        end_test("status request cancel");

        asrt = checker_failures();
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, err_cnt, asrt);
        if (err_cnt == 0 && asrt == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/mcntrl_test_pkg.sv
source/cmd_deser.sv
source/chn_frame_ctrl.sv
source/status_generate.sv
source/status_router.sv
source/mcntrl_test_top.sv
tests/mcntrl_test_checker.sv
tests/tb_mcntrl_test.sv
